// File: isa_pkg.sv
package isa_pkg;

	// raw instruction word and its fields
	typedef logic [31:0] instr_t;
	typedef logic [5:0] opcode_t;
	typedef logic [4:0] sub_base_t;
	typedef logic [7:0] sub_ls_t;
	typedef logic sub_b_t;
	typedef logic [1:0] sv_t;
	typedef logic [4:0] reg_addr_t;

	// immediates, all taken from the low end of the word
	typedef logic [4:0] imm5_t;
	typedef logic [13:0] imm14_t;
	typedef logic [14:0] imm15_t;
	typedef logic [19:0] imm20_t;
	typedef logic [23:0] imm24_t;

	// primary opcodes, bits 30:25
	localparam opcode_t OP_TY_BASE = 6'h20;
	localparam opcode_t OP_ADDI = 6'h28;
	localparam opcode_t OP_ORI = 6'h2C;
	localparam opcode_t OP_XORI = 6'h2B;
	localparam opcode_t OP_MOVI = 6'h22;
	localparam opcode_t OP_LWI = 6'h02;
	localparam opcode_t OP_SWI = 6'h0A;
	localparam opcode_t OP_TY_LS = 6'h1C;
	localparam opcode_t OP_TY_B = 6'h26;
	localparam opcode_t OP_JJ = 6'h24;

	// base group, bits 4:0
	localparam sub_base_t SB_ADD = 5'h00;
	localparam sub_base_t SB_SUB = 5'h01;
	localparam sub_base_t SB_AND = 5'h02;
	localparam sub_base_t SB_XOR = 5'h03;
	localparam sub_base_t SB_OR = 5'h04;
	localparam sub_base_t SB_SLLI = 5'h08;
	localparam sub_base_t SB_SRLI = 5'h09;
	localparam sub_base_t SB_ROTRI = 5'h0B;

	// load/store group, bits 7:0
	localparam sub_ls_t SL_LW = 8'h02;
	localparam sub_ls_t SL_SW = 8'h0A;

	// branch group, bit 14
	localparam sub_b_t SBR_BEQ = 1'b0;
	localparam sub_b_t SBR_BNE = 1'b1;

endpackage

// File: core_pkg.sv
package core_pkg;

	typedef logic [31:0] word_t;

	typedef enum logic [2:0] {
		PH_FETCH,
		PH_DECODE,
		PH_EXECUTE,
		PH_MEM,
		PH_WB,
		PH_PC
	} phase_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SRL,
		ALU_SLL,
		ALU_ROTR
	} alu_op_t;

	typedef enum logic [1:0] {IMM_ZE5, IMM_SE15, IMM_ZE15, IMM_SE20} imm_ext_t;
	typedef enum logic [1:0] {OPB_REG, OPB_IMM, OPB_IMM_SL2, OPB_REG_SV} operand_sel_t;
	typedef enum logic [1:0] {WB_ALU, WB_IMM, WB_MEM} wb_sel_t;

	typedef struct packed {
		alu_op_t alu_op;
		imm_ext_t imm_ext;
		operand_sel_t operand_sel;
		wb_sel_t wb_sel;
		logic mem_read;
		logic mem_write;
		logic reg_write;
		logic is_branch;
		logic branch_ne;
		logic is_jump;
	} ctrl_t;

	// decode to execute
	typedef struct packed {
		word_t a;
		word_t b;
		word_t store_data;
		word_t imm;
		ctrl_t ctrl;
		isa_pkg::reg_addr_t wa;
		word_t pc;
	} exec_in_t;

	// execute to memory
	typedef struct packed {
		word_t result;
		word_t store_data;
		word_t imm;
		ctrl_t ctrl;
		isa_pkg::reg_addr_t wa;
		word_t next_pc;
	} exec_out_t;

endpackage

// File: reg_file.sv
module reg_file #(
	parameter int REGS = 32
) (
	input logic clock,
	input logic reset,
	input isa_pkg::reg_addr_t ra,
	input isa_pkg::reg_addr_t rb,
	output core_pkg::word_t rdata_a,
	output core_pkg::word_t rdata_b,
	input logic we,
	input isa_pkg::reg_addr_t wa,
	input core_pkg::word_t wdata
);
	import core_pkg::*;

	word_t regs [REGS];

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (wa != '0)) begin
			regs[wa] <= wdata;
		end
	end

	// r0 is hardwired to zero
	assign rdata_a = (ra == '0) ? '0 : regs[ra];
	assign rdata_b = (rb == '0) ? '0 : regs[rb];

endmodule

// File: controller.sv
module controller (
	input logic clock,
	input logic reset,
	input isa_pkg::instr_t instruction,
	output logic fetch,
	output logic en_decode,
	output logic en_execute,
	output logic en_mem,
	output logic en_wb,
	output logic en_pc,
	output isa_pkg::instr_t ir,
	output core_pkg::ctrl_t ctrl
);
	import isa_pkg::*;
	import core_pkg::*;

	phase_t phase;
	phase_t phase_next;
	logic run;

	opcode_t opcode;
	sub_base_t sub_base;
	sub_ls_t sub_ls;
	sub_b_t sub_b;

	assign opcode = ir[30:25];
	assign sub_base = ir[4:0];
	assign sub_ls = ir[7:0];
	assign sub_b = ir[14];

	// run arms on the first edge after reset, so all strobes stay low until then
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			run <= 1'b0;
			phase <= PH_FETCH;
		end else begin
			run <= 1'b1;
			if (run) begin
				phase <= phase_next;
			end
		end
	end

	always_comb begin
		case (phase)
			PH_FETCH: phase_next = PH_DECODE;
			PH_DECODE: phase_next = PH_EXECUTE;
			PH_EXECUTE: phase_next = PH_MEM;
			PH_MEM: phase_next = PH_WB;
			PH_WB: phase_next = PH_PC;
			default: phase_next = PH_FETCH;
		endcase
	end

	assign fetch = run && (phase == PH_FETCH);
	assign en_decode = run && (phase == PH_DECODE);
	assign en_execute = run && (phase == PH_EXECUTE);
	assign en_mem = run && (phase == PH_MEM);
	assign en_wb = run && (phase == PH_WB);
	assign en_pc = run && (phase == PH_PC);

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			ir <= '0;
		end else if (fetch) begin
			ir <= instruction;
		end
	end

	// undefined encodings fall through as a no-op
	always_comb begin
		ctrl.alu_op = ALU_ADD;
		ctrl.imm_ext = IMM_ZE5;
		ctrl.operand_sel = OPB_REG;
		ctrl.wb_sel = WB_ALU;
		ctrl.mem_read = 1'b0;
		ctrl.mem_write = 1'b0;
		ctrl.reg_write = 1'b0;
		ctrl.is_branch = 1'b0;
		ctrl.branch_ne = 1'b0;
		ctrl.is_jump = 1'b0;
		case (opcode)
			OP_TY_BASE: begin
				ctrl.reg_write = 1'b1;
				ctrl.operand_sel = sub_base[3] ? OPB_IMM : OPB_REG;
				case (sub_base)
					SB_ADD: ctrl.alu_op = ALU_ADD;
					SB_SUB: ctrl.alu_op = ALU_SUB;
					SB_AND: ctrl.alu_op = ALU_AND;
					SB_XOR: ctrl.alu_op = ALU_XOR;
					SB_OR: ctrl.alu_op = ALU_OR;
					SB_SLLI: ctrl.alu_op = ALU_SLL;
					SB_SRLI: ctrl.alu_op = ALU_SRL;
					SB_ROTRI: ctrl.alu_op = ALU_ROTR;
					default: ctrl.reg_write = 1'b0;
				endcase
			end
			OP_ADDI: begin
				ctrl.operand_sel = OPB_IMM;
				ctrl.imm_ext = IMM_SE15;
				ctrl.reg_write = 1'b1;
			end
			OP_ORI: begin
				ctrl.alu_op = ALU_OR;
				ctrl.operand_sel = OPB_IMM;
				ctrl.imm_ext = IMM_ZE15;
				ctrl.reg_write = 1'b1;
			end
			OP_XORI: begin
				ctrl.alu_op = ALU_XOR;
				ctrl.operand_sel = OPB_IMM;
				ctrl.imm_ext = IMM_ZE15;
				ctrl.reg_write = 1'b1;
			end
			OP_MOVI: begin
				ctrl.imm_ext = IMM_SE20;
				ctrl.wb_sel = WB_IMM;
				ctrl.reg_write = 1'b1;
			end
			OP_LWI: begin
				ctrl.operand_sel = OPB_IMM_SL2;
				ctrl.imm_ext = IMM_SE15;
				ctrl.wb_sel = WB_MEM;
				ctrl.mem_read = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			OP_SWI: begin
				ctrl.operand_sel = OPB_IMM_SL2;
				ctrl.imm_ext = IMM_SE15;
				ctrl.mem_write = 1'b1;
			end
			OP_TY_LS: begin
				ctrl.operand_sel = OPB_REG_SV;
				ctrl.wb_sel = WB_MEM;
				ctrl.mem_read = (sub_ls == SL_LW);
				ctrl.reg_write = (sub_ls == SL_LW);
				ctrl.mem_write = (sub_ls == SL_SW);
			end
			OP_TY_B: begin
				// compare by subtraction, zero flag decides
				ctrl.alu_op = ALU_SUB;
				ctrl.is_branch = 1'b1;
				ctrl.branch_ne = (sub_b == SBR_BNE);
			end
			OP_JJ: ctrl.is_jump = 1'b1;
			default: ctrl.is_jump = 1'b0;
		endcase
	end

	enables_one_hot: assert property (@(posedge clock) disable iff (reset)
		run |-> $onehot({fetch, en_decode, en_execute, en_mem, en_wb, en_pc}));

endmodule

// File: decode_stage.sv
module decode_stage #(
	parameter int REGS = 32
) (
	input logic clock,
	input logic reset,
	input logic en_decode,
	input isa_pkg::instr_t ir,
	input core_pkg::ctrl_t ctrl,
	input core_pkg::word_t pc,
	input logic en_wb,
	input isa_pkg::reg_addr_t wb_addr,
	input core_pkg::word_t wb_data,
	input logic wb_write,
	output core_pkg::exec_in_t exec_in
);
	import isa_pkg::*;
	import core_pkg::*;

	reg_addr_t ra;
	reg_addr_t rb;
	reg_addr_t rt;
	sv_t sv;
	imm5_t imm5;
	imm14_t imm14;
	imm15_t imm15;
	imm20_t imm20;
	imm24_t imm24;
	word_t rdata_a;
	word_t rdata_b;
	word_t rdata_t;
	word_t reg_b;
	word_t imm;
	word_t opb;
	logic we;

	assign rt = ir[24:20];
	assign ra = ir[19:15];
	assign rb = ir[14:10];
	assign sv = ir[9:8];
	assign imm5 = ir[14:10];
	assign imm14 = ir[13:0];
	assign imm15 = ir[14:0];
	assign imm20 = ir[19:0];
	assign imm24 = ir[23:0];
	assign we = en_wb && wb_write;

	reg_file #(
		.REGS(REGS)
	) rf_main (
		.clock(clock),
		.reset(reset),
		.ra(ra),
		.rb(rb),
		.rdata_a(rdata_a),
		.rdata_b(rdata_b),
		.we(we),
		.wa(wb_addr),
		.wdata(wb_data)
	);

	// mirrored copy, its port a gives rt for store data and branch compare
	reg_file #(
		.REGS(REGS)
	) rf_rt (
		.clock(clock),
		.reset(reset),
		.ra(rt),
		.rb(rb),
		.rdata_a(rdata_t),
		.rdata_b(),
		.we(we),
		.wa(wb_addr),
		.wdata(wb_data)
	);

	// branch and jump offsets are halfword scaled
	always_comb begin
		if (ctrl.is_branch) begin
			imm = {{17{imm14[13]}}, imm14, 1'b0};
		end else if (ctrl.is_jump) begin
			imm = {{7{imm24[23]}}, imm24, 1'b0};
		end else begin
			case (ctrl.imm_ext)
				IMM_ZE5: imm = {27'b0, imm5};
				IMM_SE15: imm = {{17{imm15[14]}}, imm15};
				IMM_ZE15: imm = {17'b0, imm15};
				default: imm = {{12{imm20[19]}}, imm20};
			endcase
		end
	end

	assign reg_b = ctrl.is_branch ? rdata_t : rdata_b;

	always_comb begin
		case (ctrl.operand_sel)
			OPB_REG: opb = reg_b;
			OPB_IMM: opb = imm;
			OPB_IMM_SL2: opb = imm << 2;
			default: opb = rdata_b << sv;
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			exec_in <= '0;
		end else if (en_decode) begin
			exec_in.a <= rdata_a;
			exec_in.b <= opb;
			exec_in.store_data <= rdata_t;
			exec_in.imm <= imm;
			exec_in.ctrl <= ctrl;
			exec_in.wa <= rt;
			exec_in.pc <= pc;
		end
	end

endmodule

// File: execute_stage.sv
module execute_stage (
	input logic clock,
	input logic reset,
	input logic en_execute,
	input core_pkg::exec_in_t exec_in,
	output core_pkg::exec_out_t exec_out
);
	import core_pkg::*;

	word_t alu_result;
	word_t next_pc;
	logic [63:0] rot;
	logic [4:0] shamt;
	logic zero;
	logic taken;

	assign shamt = exec_in.b[4:0];
	// rotate right via doubled word
	assign rot = {exec_in.a, exec_in.a} >> shamt;

	always_comb begin
		case (exec_in.ctrl.alu_op)
			ALU_SUB: alu_result = exec_in.a - exec_in.b;
			ALU_AND: alu_result = exec_in.a & exec_in.b;
			ALU_OR: alu_result = exec_in.a | exec_in.b;
			ALU_XOR: alu_result = exec_in.a ^ exec_in.b;
			ALU_SRL: alu_result = exec_in.a >> shamt;
			ALU_SLL: alu_result = exec_in.a << shamt;
			ALU_ROTR: alu_result = rot[31:0];
			default: alu_result = exec_in.a + exec_in.b;
		endcase
	end

	assign zero = (alu_result == '0);
	assign taken = exec_in.ctrl.is_jump ||
		(exec_in.ctrl.is_branch && (zero != exec_in.ctrl.branch_ne));
	assign next_pc = taken ? exec_in.pc + exec_in.imm : exec_in.pc + 32'd4;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			exec_out <= '0;
		end else if (en_execute) begin
			exec_out.result <= alu_result;
			exec_out.store_data <= exec_in.store_data;
			exec_out.imm <= exec_in.imm;
			exec_out.ctrl <= exec_in.ctrl;
			exec_out.wa <= exec_in.wa;
			exec_out.next_pc <= next_pc;
		end
	end

endmodule

// File: data_mem.sv
module data_mem #(
	parameter int DEPTH = 64
) (
	input logic clock,
	input logic reset,
	input logic en_mem,
	input core_pkg::exec_out_t exec_out,
	output core_pkg::word_t wb_data
);
	import core_pkg::*;

	localparam int AW = $clog2(DEPTH);

	word_t mem [DEPTH];
	word_t rdata;
	logic [AW-1:0] index;

	// word address wraps at DEPTH
	assign index = AW'((exec_out.result >> 2) % DEPTH);
	assign rdata = exec_out.ctrl.mem_read ? mem[index] : '0;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0;
			end
			wb_data <= '0;
		end else if (en_mem) begin
			if (exec_out.ctrl.mem_write) begin
				mem[index] <= exec_out.store_data;
			end
			case (exec_out.ctrl.wb_sel)
				WB_IMM: wb_data <= exec_out.imm;
				WB_MEM: wb_data <= rdata;
				default: wb_data <= exec_out.result;
			endcase
		end
	end

	no_read_and_write: assert property (@(posedge clock) disable iff (reset)
		en_mem |-> !(exec_out.ctrl.mem_read && exec_out.ctrl.mem_write));

endmodule

// File: cpu_core.sv
module cpu_core #(
	parameter int DEPTH = 64,
	parameter int REGS = 32
) (
	input logic clock,
	input logic reset,
	output core_pkg::word_t pc,
	output logic fetch,
	input isa_pkg::instr_t instruction,
	output logic wb_valid,
	output isa_pkg::reg_addr_t wb_addr,
	output core_pkg::word_t wb_data
);
	import isa_pkg::*;
	import core_pkg::*;

	logic en_decode;
	logic en_execute;
	logic en_mem;
	logic en_wb;
	logic en_pc;
	instr_t ir;
	ctrl_t ctrl;
	exec_in_t exec_in;
	exec_out_t exec_out;

	controller controller_inst (
		.clock(clock),
		.reset(reset),
		.instruction(instruction),
		.fetch(fetch),
		.en_decode(en_decode),
		.en_execute(en_execute),
		.en_mem(en_mem),
		.en_wb(en_wb),
		.en_pc(en_pc),
		.ir(ir),
		.ctrl(ctrl)
	);

	decode_stage #(
		.REGS(REGS)
	) decode_inst (
		.clock(clock),
		.reset(reset),
		.en_decode(en_decode),
		.ir(ir),
		.ctrl(ctrl),
		.pc(pc),
		.en_wb(en_wb),
		.wb_addr(wb_addr),
		.wb_data(wb_data),
		.wb_write(exec_out.ctrl.reg_write),
		.exec_in(exec_in)
	);

	execute_stage execute_inst (
		.clock(clock),
		.reset(reset),
		.en_execute(en_execute),
		.exec_in(exec_in),
		.exec_out(exec_out)
	);

	data_mem #(
		.DEPTH(DEPTH)
	) data_mem_inst (
		.clock(clock),
		.reset(reset),
		.en_mem(en_mem),
		.exec_out(exec_out),
		.wb_data(wb_data)
	);

	// writes to r0 are dropped and not reported
	assign wb_addr = exec_out.wa;
	assign wb_valid = en_wb && exec_out.ctrl.reg_write && (exec_out.wa != '0);

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pc <= '0;
		end else if (en_pc) begin
			pc <= exec_out.next_pc;
		end
	end

endmodule

// File: tb_cpu_core.sv
module tb_cpu_core;
	import isa_pkg::*;
	import core_pkg::*;

	localparam int PERIOD = 20;
	localparam int RESET_CYCLES = 10;
	localparam int DRIVE_DELAY = 2;
	localparam int PHASES = 6;
	localparam int WB_CYCLE = 4;
	localparam int MAX_ENTRIES = 63;

	logic clock;
	logic reset;
	word_t pc;
	logic fetch;
	instr_t instruction;
	logic wb_valid;
	reg_addr_t wb_addr;
	word_t wb_data;

	// word 0 is the entry count, four words per entry after it
	logic [31:0] golden [256];
	int entries;
	int tests;
	int errors;
	logic loaded;
	logic stop;

	cpu_core #(
		.DEPTH(64),
		.REGS(32)
	) cpu_core_inst (
		.clock(clock),
		.reset(reset),
		.pc(pc),
		.fetch(fetch),
		.instruction(instruction),
		.wb_valid(wb_valid),
		.wb_addr(wb_addr),
		.wb_data(wb_data)
	);

	always #(PERIOD / 2) clock = ~clock;

	task automatic check_word(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			errors++;
			$display("FAILED %s: expected %h, got %h", name, expected, actual);
		end
	endtask

	task automatic wait_fetch(output logic found);
		found = 1'b0;
		for (int cycle = 0; cycle < PHASES && !found; cycle++) begin
			@(posedge clock);
			#DRIVE_DELAY;
			found = fetch;
		end
	endtask

	// called in a fetch cycle, steps through the six phases
	task automatic run_instruction();
		logic [7:0] base;
		int errors_before;
		word_t start_pc;
		logic [31:0] flags;
		word_t exp_value;
		word_t exp_next;
		start_pc = pc;
		base = 8'(1 + 4 * int'(pc[31:2]));
		flags = golden[base + 8'd1];
		exp_value = golden[base + 8'd2];
		exp_next = golden[base + 8'd3];
		errors_before = errors;
		instruction = golden[base];
		for (int cycle = 1; cycle <= PHASES; cycle++) begin
			@(posedge clock);
			#DRIVE_DELAY;
			if (cycle == WB_CYCLE) begin
				check_word("wb_valid", 32'(flags[8]), 32'(wb_valid));
				if (flags[8]) begin
					check_word("wb_addr", 32'(flags[4:0]), 32'(wb_addr));
					check_word("wb_data", exp_value, wb_data);
				end
			end else begin
				check_word("wb_valid", 32'h0, 32'(wb_valid));
			end
			if (cycle < PHASES) begin
				// pc holds until the edge that ends the last phase
				check_word("pc", start_pc, pc);
				assert (!fetch) else begin
					errors++;
					$display("extra fetch strobe %0d cycles after the fetch at pc %h",
						cycle, start_pc);
				end
			end
		end
		assert (fetch) else begin
			errors++;
			stop = 1'b1;
			$display("missing fetch strobe %0d cycles after the fetch at pc %h",
				PHASES, start_pc);
		end
		check_word("pc", exp_next, pc);
		tests++;
		$display("test %0d at pc %h, instruction %h: %s", tests, start_pc,
			golden[base], (errors == errors_before) ? "ok" : "mismatch");
	endtask

	initial begin
		logic found;
		clock = 1'b0;
		reset = 1'b1;
		instruction = '0;
		tests = 0;
		errors = 0;
		stop = 1'b0;
		loaded = 1'b0;
		$readmemh("cpu_core_golden.txt", golden);
		entries = int'(golden[0]);
		assert (entries > 0 && entries <= MAX_ENTRIES) else begin
			errors++;
			$display("golden file gives %0d entries, allowed are 1 to %0d",
				entries, MAX_ENTRIES);
			entries = 0;
		end
		loaded = 1'b1;
		// strobes stay low while reset is held
		repeat (RESET_CYCLES) begin
			@(posedge clock);
			#DRIVE_DELAY;
			check_word("fetch", 32'h0, 32'(fetch));
			check_word("wb_valid", 32'h0, 32'(wb_valid));
		end
		reset = 1'b0;
		wait_fetch(found);
		assert (found) else begin
			errors++;
			stop = 1'b1;
			$display("no fetch strobe within %0d cycles after reset", PHASES);
		end
		check_word("pc", 32'h0, pc);
		while (!stop && pc[1:0] == 2'b00 && int'(pc[31:2]) < entries) begin
			run_instruction();
		end
		// the program runs off its last entry
		check_word("pc", 32'(4 * entries), pc);
		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin
		int limit;
		wait (loaded);
		limit = (entries * PHASES + RESET_CYCLES + 20) * PERIOD;
		#limit;
		$display("timeout, the program did not finish within %0d time units", limit);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: cpu_core.f
isa_pkg.sv
core_pkg.sv
reg_file.sv
controller.sv
decode_stage.sv
execute_stage.sv
data_mem.sv
cpu_core.sv
tb_cpu_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_cpu_core
FILELIST ?= cpu_core.f
BUILD_DIR ?= obj_dir
SOURCES ?= $(shell cat $(FILELIST))
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert
PASS_TEXT ?= TEST PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: cpu_core_golden.txt
// columns: instruction, write flag and index (100 + register, 0 for none), value, next pc
// the first word is the number of entries, entry n sits at pc 4*n
00000021
44112345 101 00012345 00000004 // movi r1
442FFFF0 102 FFFFFFF0 00000008 // movi r2, negative
40308800 103 00012335 0000000C // add r3, r1, r2
40408801 104 00012355 00000010 // sub r4, r1, r2
40508802 105 00012340 00000014 // and r5, r1, r2
40608803 106 FFFEDCB5 00000018 // xor r6, r1, r2
40708804 107 FFFFFFF5 0000001C // or r7, r1, r2
40809008 108 00123450 00000020 // slli r8, r1, 4
40912009 109 00FFFFFF 00000024 // srli r9, r2, 8
40A0900B 10A 50001234 00000028 // rotri r10, r1, 4
40008400 000 00000000 0000002C // add r0, write dropped
40B00400 10B 00012345 00000030 // add r11, r0, r1
50C0FFFF 10C 00012344 00000034 // addi r12, r1, -1
58D0CF00 10D 00016F45 00000038 // ori r13, r1, 4f00
56E14000 10E FFFFBFF0 0000003C // xori r14, r2, 4000
14100003 000 00000000 00000040 // swi r1 to word 3
04F00003 10F 00012345 00000044 // lwi r15 from word 3
45000005 110 00000005 00000048 // movi r16, 5
3820420A 000 00000000 0000004C // sw r2 to r16 << 2
39104202 111 FFFFFFF0 00000050 // lw r17 from r16 << 2
05200005 112 FFFFFFF0 00000054 // lwi r18 from word 5
4C208004 000 00000000 00000058 // beq r1, r2, not taken
4CF08004 000 00000000 00000060 // beq r1, r15, taken
44100BAD 101 00000BAD 00000060 // skipped
4C20C004 000 00000000 00000068 // bne r1, r2, taken
44100BAD 101 00000BAD 00000068 // skipped
4CF0C004 000 00000000 0000006C // bne r1, r15, not taken
48000006 000 00000000 00000078 // jj +12
44100BAD 101 00000BAD 00000074 // skipped
44100BAD 101 00000BAD 00000078 // skipped
7E100000 000 00000000 0000007C // undefined opcode
4010801F 000 00000000 00000080 // undefined base sub-op
41308000 113 00012345 00000084 // add r19, r1, r0
